//--- verif/videoMixTbTasks.svh
// Included inside the testbench module. Uses its DUT signals and its error and check counters
`ifndef VIDEO_MIX_TB_TASKS_SVH
`define VIDEO_MIX_TB_TASKS_SVH

// Action of one table row in its cycle
typedef enum logic [2:0] {
	PhIdle,
	PhRenderLoad,
	PhRender,
	PhDisplayLoad,
	PhDisplay,
	PhBoth,
	PhFlip
} phaseT;

// One cycle of stimulus and the address due two edges later
typedef struct packed {
	phaseT phase;
	logic [LbAddrWidth-1:0] x;
	lbEntryT sprite;
	logic [ColorWidth-1:0] fixColor;
	logic [FixPalWidth-1:0] fixPal;
	logic blank;
	logic cpuPalSel;
	logic [PalAddrWidth-1:0] cpuAddr;
	logic [PalAddrWidth-1:0] expAddr;
} stimRowT;

task automatic checkPalAddr(input logic [PalAddrWidth-1:0] expected);
	checks++;
	if (paletteAddr !== expected)
	begin
		errors++;
		testErrors++;
		$display("Mismatch at %0t ns: paletteAddr expected %h, got %h",
			$time, expected, paletteAddr);
	end
endtask

task automatic checkReset(input logic expected);
	checks++;
	if (cpuReset !== expected)
	begin
		errors++;
		testErrors++;
		$display("Mismatch at %0t ns: cpuReset expected %b, got %b", $time, expected, cpuReset);
	end
endtask

// Puts one row on the DUT inputs
task automatic driveRow(input stimRowT r);
	xLoad = r.x;
	renderLoad = (r.phase == PhRenderLoad);
	renderEn = (r.phase == PhRender) || (r.phase == PhBoth);
	displayLoad = (r.phase == PhDisplayLoad);
	displayEn = (r.phase == PhDisplay) || (r.phase == PhBoth);
	bufferFlip = (r.phase == PhFlip);
	spriteColor = r.sprite.color;
	spritePal = r.sprite.pal;
	fixColor = r.fixColor;
	fixPal = r.fixPal;
	blank = r.blank;
	cpuPalSel = r.cpuPalSel;
	cpuAddr = r.cpuAddr;
endtask

`endif

//--- verif/videoMixTb.sv
// Drives videoMixTop from row tables and checks paletteAddr at the fixed two-edge display latency
`timescale 1ns/1ps
`default_nettype none

module videoMixTb
	import videoMixPkg::*;
();

	localparam int LineLen = 16;
	// Upper bound on table rows over all pixel tests
	localparam int MaxRows = 20 * LineLen;

	logic PCK = 1'b0;
	logic reset;
	logic [LbAddrWidth-1:0] xLoad;
	logic renderLoad;
	logic renderEn;
	logic [ColorWidth-1:0] spriteColor;
	logic [SprPalWidth-1:0] spritePal;
	logic displayLoad;
	logic displayEn;
	logic bufferFlip;
	logic [ColorWidth-1:0] fixColor;
	logic [FixPalWidth-1:0] fixPal;
	logic blank;
	logic cpuPalSel;
	logic [PalAddrWidth-1:0] cpuAddr;
	logic cpuWdKick;
	logic [PalAddrWidth-1:0] paletteAddr;
	logic cpuReset;

	int seed = 32'h3074;
	int errors = 0;
	int testErrors = 0;
	int checks = 0;
	int testsRun = 0;
	int testsFailing = 0;

	`include "videoMixTbTasks.svh"

	stimRowT rows [$];

	videoMixTop u_dut (.*);

	always #10 PCK = ~PCK;

	// Run limit from table rows plus the watchdog test length
	initial
	begin
		#((MaxRows + 4 * WatchdogLimit + 50) * 20);
		$display("Timeout, the run did not reach its end in time");
		$display("test failed");
		$finish;
	end

	// Random sprite word, every fourth slot forced transparent
	function automatic lbEntryT randEntry(input int k);
		logic [31:0] r;
		r = $random(seed);
		if (k % 4 == 3)
			r[3:0] = '0;
		return r[11:0];
	endfunction

	// Opaque sprite shows palette and colour, colour 0 shows the backdrop
	function automatic logic [PalAddrWidth-1:0] spriteExp(input lbEntryT e);
		return (e.color != '0) ? {e.pal, e.color} : BackdropAddr;
	endfunction

	task automatic addRow(input phaseT ph, input logic [7:0] x, input lbEntryT spr,
		input logic [3:0] fc, input logic [3:0] fp, input logic bl, input logic cs,
		input logic [11:0] ca, input logic [11:0] ex);
		stimRowT r;
		r = '{ph, x, spr, fc, fp, bl, cs, ca, ex};
		rows.push_back(r);
	endtask

	// Load, flip or idle row with nothing else driven
	task automatic addCtl(input phaseT ph, input logic [7:0] x);
		addRow(ph, x, '0, '0, '0, 1'b0, 1'b0, '0, '0);
	endtask

	// Counter load then one write per entry
	task automatic addRender(input logic [7:0] x, input lbEntryT line [LineLen]);
		addCtl(PhRenderLoad, x);
		for (int k = 0; k < LineLen; k++)
			addRow(PhRender, '0, line[k], '0, '0, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic reportTest(input string name);
		testsRun++;
		if (testErrors != 0)
			testsFailing++;
		$display("[%0t ns] %s: %0s, %0d errors", $time, name,
			(testErrors == 0) ? "ok" : "FAIL", testErrors);
	endtask

	// Applies the queued rows, checking each display row two edges later
	task automatic applyTable(input string name);
		stimRowT r;
		int n;
		n = rows.size();
		testErrors = 0;
		for (int i = 0; i < n + 2; i++)
		begin
			@(posedge PCK);
			#1;
			if (i >= 2 && (rows[i-2].phase == PhDisplay || rows[i-2].phase == PhBoth))
				checkPalAddr(rows[i-2].expAddr);
			r = '0;
			if (i < n)
				r = rows[i];
			driveRow(r);
		end
		rows.delete();
		reportTest(name);
	endtask

	// Kick held for len edges
	task automatic kick(input int len);
		@(posedge PCK);
		#1 cpuWdKick = 1'b1;
		repeat (len) @(posedge PCK);
		#1 cpuWdKick = 1'b0;
	endtask

	initial
	begin
		lbEntryT lineA [LineLen];
		lbEntryT lineB [LineLen];
		logic [31:0] r;
		logic bl;
		logic cs;
		logic [PalAddrWidth-1:0] ex;
		int k;
		driveRow('0);
		cpuWdKick = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge PCK);
		#1 reset = 1'b0;

		// Render A, flip, scan it out
		for (k = 0; k < LineLen; k++)
			lineA[k] = randEntry(k);
		addRender(8'h40, lineA);
		addCtl(PhFlip, '0);
		addCtl(PhDisplayLoad, 8'h40);
		for (k = 0; k < LineLen; k++)
			addRow(PhDisplay, '0, '0, '0, '0, 1'b0, 1'b0, '0, spriteExp(lineA[k]));
		applyTable("sprite path and transparency");

		// Same line again, the first read emptied it
		addCtl(PhFlip, '0);
		addCtl(PhFlip, '0);
		addCtl(PhDisplayLoad, 8'h40);
		for (k = 0; k < LineLen; k++)
			addRow(PhDisplay, '0, '0, '0, '0, 1'b0, 1'b0, '0, BackdropAddr);
		applyTable("clear on read");

		// Fix layer over sprites on even pixels
		for (k = 0; k < LineLen; k++)
			lineB[k] = randEntry(k);
		addRender(8'h80, lineB);
		addCtl(PhFlip, '0);
		addCtl(PhDisplayLoad, 8'h80);
		for (k = 0; k < LineLen; k++)
		begin
			r = $random(seed);
			r[3:0] = (k % 2 == 0) ? (r[3:0] | 4'h1) : 4'h0;
			ex = (r[3:0] != '0) ? PalAddrWidth'({r[7:4], r[3:0]}) : spriteExp(lineB[k]);
			addRow(PhDisplay, '0, '0, r[3:0], r[7:4], 1'b0, 1'b0, '0, ex);
		end
		applyTable("fix priority");

		// Blank and CPU select over opaque fix and sprite
		for (k = 0; k < LineLen; k++)
			lineA[k] = randEntry(k);
		addRender(8'hC0, lineA);
		addCtl(PhFlip, '0);
		addCtl(PhDisplayLoad, 8'hC0);
		for (k = 0; k < LineLen; k++)
		begin
			r = $random(seed);
			bl = (k % 3 == 0) || ((k % 3 == 1) && r[12]);
			cs = (k % 3 == 1);
			ex = cs ? r[27:16] : (bl ? '0 : spriteExp(lineA[k]));
			addRow(PhDisplay, '0, '0, (bl || cs) ? r[3:0] : 4'h0, r[7:4], bl, cs, r[27:16], ex);
		end
		applyTable("blank and cpu priority");

		// Fill B, then write A ahead of the B read address while B scans out, then scan A
		for (k = 0; k < LineLen; k++)
		begin
			lineB[k] = randEntry(k);
			lineA[k] = randEntry(k + 1);
		end
		addRender(8'h20, lineB);
		addCtl(PhFlip, '0);
		addCtl(PhRenderLoad, 8'h28);
		addCtl(PhDisplayLoad, 8'h20);
		for (k = 0; k < LineLen; k++)
			addRow(PhBoth, '0, lineA[k], '0, '0, 1'b0, 1'b0, '0, spriteExp(lineB[k]));
		addCtl(PhFlip, '0);
		addCtl(PhDisplayLoad, 8'h28);
		for (k = 0; k < LineLen; k++)
			addRow(PhDisplay, '0, '0, '0, '0, 1'b0, 1'b0, '0, spriteExp(lineA[k]));
		applyTable("ping-pong");

		// Long first kick also rides out a pulse already running
		testErrors = 0;
		kick(ResetPulseLen + 1);
		repeat (2)
		begin
			for (k = 1; k <= WatchdogLimit - 20; k++)
			begin
				@(posedge PCK);
				#1 checkReset(1'b0);
			end
			kick(1);
		end
		// High from one cycle past the limit for the pulse length
		for (k = 1; k <= WatchdogLimit + ResetPulseLen + 2; k++)
		begin
			@(posedge PCK);
			#1 checkReset((k > WatchdogLimit) && (k <= WatchdogLimit + ResetPulseLen));
		end
		reportTest("watchdog");

		$display("Tests run %0d, tests failing %0d, checks %0d, errors %0d",
			testsRun, testsFailing, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cpuWatchdog.sv
// Kicks during the reset pulse are ignored. Counting restarts from zero once the pulse ends
`timescale 1ns/1ps
`default_nettype none

module cpuWatchdog
	import videoMixPkg::*;
(
	input logic PCK,
	input logic reset,
	input logic cpuWdKick,
	output logic cpuReset
);

	wdStateT wdState;
	// Idle cycles in WdRun, pulse cycles in WdReset
	logic [WdCountWidth-1:0] wdCount;

	logic expired;
	logic pulseDone;

	assign expired = (wdCount == WdCountWidth'(WatchdogLimit));
	assign pulseDone = (wdCount == WdCountWidth'(ResetPulseLen - 1));

	always_ff @(posedge PCK)
	begin
		if (reset)
		begin
			wdState <= WdRun;
			wdCount <= '0;
		end
		else
		begin
			case (wdState)
				WdRun:
				begin
					// Kick wins over expiry
					if (cpuWdKick)
						wdCount <= '0;
					else if (expired)
					begin
						wdState <= WdReset;
						wdCount <= '0;
					end
					else
						wdCount <= wdCount + 1'b1;
				end
				WdReset:
				begin
					if (pulseDone)
					begin
						wdState <= WdRun;
						wdCount <= '0;
					end
					else
						wdCount <= wdCount + 1'b1;
				end
				default:
				begin
					wdState <= WdRun;
					wdCount <= '0;
				end
			endcase
		end
	end

	// Pulse follows the state register directly
	assign cpuReset = (wdState == WdReset);

	assert property (@(posedge PCK) disable iff (reset)
		$rose(cpuReset) |-> ##ResetPulseLen !cpuReset);

endmodule

`default_nettype wire

//--- verilog/lbPortIf.sv
// One address-counter port of a line buffer. A port either writes or reads, never both in one role
`timescale 1ns/1ps
`default_nettype none

interface lbPortIf
	import videoMixPkg::*;
();

	// Counter load and its start value
	logic load;
	logic [LbAddrWidth-1:0] startAddr;

	// Write side
	logic writeEn;
	lbEntryT writeData;

	// Read side, data registered inside the buffer
	logic readEn;
	lbEntryT readData;

	// Sprite renderer filling a line
	modport render (output load, startAddr, writeEn, writeData);

	// Display scan-out
	modport display (output load, startAddr, readEn, input readData);

	// Storage side
	modport buffer (input load, startAddr, writeEn, writeData, readEn, output readData);

endinterface

`default_nettype wire

//--- verilog/lineBuffer.sv
// Memory has no reset and powers up unknown. Every entry must be written or cleared by a read before it shows
`timescale 1ns/1ps
`default_nettype none

module lineBuffer
	import videoMixPkg::*;
(
	input logic PCK,
	input logic reset,
	lbPortIf.buffer wr,
	lbPortIf.buffer rd
);

	// One sprite line
	lbEntryT mem [LbDepth];

	// Independent write and read counters
	logic [LbAddrWidth-1:0] wrAddr;
	logic [LbAddrWidth-1:0] rdAddr;
	lbEntryT readReg;

	logic doWrite;
	logic doClear;

	// Load wins over a transfer in the same cycle
	assign doWrite = wr.writeEn && !wr.load;
	assign doClear = rd.readEn && !rd.load;

	// Address counters
	always_ff @(posedge PCK)
	begin
		if (reset)
		begin
			wrAddr <= '0;
			rdAddr <= '0;
		end
		else
		begin
			if (wr.load)
				wrAddr <= wr.startAddr;
			else if (wr.writeEn)
				wrAddr <= wrAddr + 1'b1;
			if (rd.load)
				rdAddr <= rd.startAddr;
			else if (rd.readEn)
				rdAddr <= rdAddr + 1'b1;
		end
	end

	// Storage with render write and clear-on-read
	always_ff @(posedge PCK)
	begin
		if (doWrite)
			mem[wrAddr] <= wr.writeData;
		if (doClear)
		begin
			readReg <= mem[rdAddr];
			// Colour 0 leaves the slot transparent for the next line
			mem[rdAddr] <= '0;
		end
	end

	assign rd.readData = readReg;
	// Write port carries no read data
	assign wr.readData = '0;

	// Bank keeps render and display on different buffers
	assert property (@(posedge PCK) disable iff (reset)
		(doWrite && doClear) |-> (wrAddr != rdAddr));

endmodule

`default_nettype wire

//--- verilog/pixelMixer.sv
// Layer inputs are taken one cycle ahead of the sprite pixel. Output address lags the sprite pixel by one cycle
`timescale 1ns/1ps
`default_nettype none

module pixelMixer
	import videoMixPkg::*;
(
	input logic PCK,
	input logic reset,
	input lbEntryT spritePixel,
	input logic spriteValid,
	input logic [ColorWidth-1:0] fixColor,
	input logic [FixPalWidth-1:0] fixPal,
	input logic blank,
	input logic cpuPalSel,
	input logic [PalAddrWidth-1:0] cpuAddr,
	output logic [PalAddrWidth-1:0] paletteAddr
);

	// Padding of the fix palette up to a full palette address
	localparam int FixPadWidth = PalAddrWidth - FixPalWidth - ColorWidth;

	// Inputs aligned with the line buffer read
	logic [ColorWidth-1:0] fixColorD;
	logic [FixPalWidth-1:0] fixPalD;
	logic [PalAddrWidth-1:0] cpuAddrD;
	logic blankD;
	logic cpuPalSelD;

	pixSrcT pixSrc;

	// Control bits of the delay stage
	always_ff @(posedge PCK)
	begin
		if (reset)
		begin
			blankD <= 1'b0;
			cpuPalSelD <= 1'b0;
		end
		else
		begin
			blankD <= blank;
			cpuPalSelD <= cpuPalSel;
		end
	end

	// Pixel data of the delay stage
	always_ff @(posedge PCK)
	begin
		fixColorD <= fixColor;
		fixPalD <= fixPal;
		cpuAddrD <= cpuAddr;
	end

	// Priority pick
	always_comb
	begin
		if (cpuPalSelD)
			pixSrc = SrcCpu;
		else if (blankD)
			pixSrc = SrcBlank;
		// Fix colour 0 is see-through
		else if (fixColorD != '0)
			pixSrc = SrcFix;
		else if (spriteValid && (spritePixel.color != '0))
			pixSrc = SrcSprite;
		else
			pixSrc = SrcBackdrop;
	end

	// Registered palette address
	always_ff @(posedge PCK)
	begin
		if (reset)
			paletteAddr <= '0;
		else
		begin
			case (pixSrc)
				SrcCpu:
					paletteAddr <= cpuAddrD;
				SrcBlank:
					paletteAddr <= '0;
				SrcFix:
					paletteAddr <= {{FixPadWidth{1'b0}}, fixPalD, fixColorD};
				SrcSprite:
					paletteAddr <= {spritePixel.pal, spritePixel.color};
				default:
					paletteAddr <= BackdropAddr;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/spriteLineBank.sv
// Flip must not land in a cycle with a render or display enable. Roles swap only between lines
`timescale 1ns/1ps
`default_nettype none

module spriteLineBank
	import videoMixPkg::*;
(
	input logic PCK,
	input logic reset,
	input logic [LbAddrWidth-1:0] xLoad,
	input logic renderLoad,
	input logic renderEn,
	input lbEntryT renderData,
	input logic displayLoad,
	input logic displayEn,
	input logic bufferFlip,
	output lbEntryT spritePixel,
	output logic spriteValid
);

	// Buffer currently filled by the renderer
	bufSelT renderSel;
	// Render selection seen by the read in flight
	bufSelT readSel;

	logic renderA;

	// Write and read ports per buffer
	lbPortIf wrA ();
	lbPortIf rdA ();
	lbPortIf wrB ();
	lbPortIf rdB ();

	assign renderA = (renderSel == BufA);

	// Render side goes to the selected buffer
	assign wrA.load = renderA && renderLoad;
	assign wrA.startAddr = xLoad;
	assign wrA.writeEn = renderA && renderEn;
	assign wrA.writeData = renderData;
	assign wrA.readEn = 1'b0;

	assign wrB.load = !renderA && renderLoad;
	assign wrB.startAddr = xLoad;
	assign wrB.writeEn = !renderA && renderEn;
	assign wrB.writeData = renderData;
	assign wrB.readEn = 1'b0;

	// Display side reads the other one
	assign rdA.load = !renderA && displayLoad;
	assign rdA.startAddr = xLoad;
	assign rdA.readEn = !renderA && displayEn;
	assign rdA.writeEn = 1'b0;
	assign rdA.writeData = '0;

	assign rdB.load = renderA && displayLoad;
	assign rdB.startAddr = xLoad;
	assign rdB.readEn = renderA && displayEn;
	assign rdB.writeEn = 1'b0;
	assign rdB.writeData = '0;

	lineBuffer bufA (
		.PCK(PCK),
		.reset(reset),
		.wr(wrA),
		.rd(rdA)
	);

	lineBuffer bufB (
		.PCK(PCK),
		.reset(reset),
		.wr(wrB),
		.rd(rdB)
	);

	// Role swap, valid flag and read-side selection
	always_ff @(posedge PCK)
	begin
		if (reset)
		begin
			renderSel <= BufA;
			readSel <= BufA;
			spriteValid <= 1'b0;
		end
		else
		begin
			if (bufferFlip)
				renderSel <= renderA ? BufB : BufA;
			readSel <= renderSel;
			// Read data shows one cycle after its enable
			spriteValid <= displayEn;
		end
	end

	// Pick the buffer that was the display side when the read was issued
	assign spritePixel = (readSel == BufA) ? rdB.readData : rdA.readData;

	assert property (@(posedge PCK) disable iff (reset)
		bufferFlip |-> !(renderEn || displayEn));

endmodule

`default_nettype wire

//--- verilog/videoMixPkg.sv
// All widths and limits are fixed here. Nothing is configurable per instance and one pixel passes per PCK cycle
`default_nettype none

package videoMixPkg;

	// Line buffer geometry
	localparam int LbDepth = 256;
	localparam int LbAddrWidth = 8;

	// Pixel field widths
	localparam int ColorWidth = 4;
	localparam int SprPalWidth = 8;
	localparam int FixPalWidth = 4;
	localparam int PalAddrWidth = 12;

	// Shown where no layer is opaque
	localparam logic [PalAddrWidth-1:0] BackdropAddr = '1;

	// Watchdog timing in PCK cycles
	localparam int WatchdogLimit = 200;
	localparam int ResetPulseLen = 8;
	// One counter serves both the idle count and the pulse length
	localparam int WdCountWidth = $clog2(WatchdogLimit + 1);

	// Line buffer word, palette in the upper bits
	typedef struct packed {
		logic [SprPalWidth-1:0] pal;
		logic [ColorWidth-1:0] color;
	} lbEntryT;

	// Which buffer takes render writes
	typedef enum logic {
		BufA,
		BufB
	} bufSelT;

	// Source picked for one output pixel, highest priority first
	typedef enum logic [2:0] {
		SrcCpu,
		SrcBlank,
		SrcFix,
		SrcSprite,
		SrcBackdrop
	} pixSrcT;

	typedef enum logic {
		WdRun,
		WdReset
	} wdStateT;

endpackage

`default_nettype wire

//--- verilog/videoMixTop.sv
// Fixed video timing with no stall. paletteAddr is valid two cycles after displayEn
`timescale 1ns/1ps
`default_nettype none

module videoMixTop
	import videoMixPkg::*;
(
	input logic PCK,
	input logic reset,
	input logic [LbAddrWidth-1:0] xLoad,
	input logic renderLoad,
	input logic renderEn,
	input logic [ColorWidth-1:0] spriteColor,
	input logic [SprPalWidth-1:0] spritePal,
	input logic displayLoad,
	input logic displayEn,
	input logic bufferFlip,
	input logic [ColorWidth-1:0] fixColor,
	input logic [FixPalWidth-1:0] fixPal,
	input logic blank,
	input logic cpuPalSel,
	input logic [PalAddrWidth-1:0] cpuAddr,
	input logic cpuWdKick,
	output logic [PalAddrWidth-1:0] paletteAddr,
	output logic cpuReset
);

	// Render word as stored in the line buffer
	lbEntryT renderData;

	// Bank to mixer
	lbEntryT spritePixel;
	logic spriteValid;

	assign renderData = {spritePal, spriteColor};

	spriteLineBank lineBank (
		.PCK(PCK),
		.reset(reset),
		.xLoad(xLoad),
		.renderLoad(renderLoad),
		.renderEn(renderEn),
		.renderData(renderData),
		.displayLoad(displayLoad),
		.displayEn(displayEn),
		.bufferFlip(bufferFlip),
		.spritePixel(spritePixel),
		.spriteValid(spriteValid)
	);

	pixelMixer mixer (
		.PCK(PCK),
		.reset(reset),
		.spritePixel(spritePixel),
		.spriteValid(spriteValid),
		.fixColor(fixColor),
		.fixPal(fixPal),
		.blank(blank),
		.cpuPalSel(cpuPalSel),
		.cpuAddr(cpuAddr),
		.paletteAddr(paletteAddr)
	);

	// Independent of the pixel path
	cpuWatchdog watchdog (
		.PCK(PCK),
		.reset(reset),
		.cpuWdKick(cpuWdKick),
		.cpuReset(cpuReset)
	);

endmodule

`default_nettype wire

//--- videoMixTop.f
+incdir+verif
verilog/videoMixPkg.sv
verilog/lbPortIf.sv
verilog/lineBuffer.sv
verilog/spriteLineBank.sv
verilog/pixelMixer.sv
verilog/cpuWatchdog.sv
verilog/videoMixTop.sv
verif/videoMixTb.sv
